// ==== verification/statusTestdata.txt ====
// hold intAck rti cmd wrData aluValid aluFlags | astat mstat imask stkTop topValid
// stkEmpty stkFull stkHas1 stkOverflow stkUnderflow (all hex, expected after the edge)
0 0 0 0 000 0 00 00 00 000 0000000 0 1 0 0 0 0
0 0 0 3 0a5 0 00 a5 00 000 0000000 0 1 0 0 0 0
0 0 0 4 055 0 00 a5 55 000 0000000 0 1 0 0 0 0
0 0 0 5 3c3 0 00 a5 55 3c3 0000000 0 1 0 0 0 0
0 0 0 0 000 1 12 12 55 3c3 0000000 0 1 0 0 0 0
0 0 0 3 177 1 ff 77 55 3c3 0000000 0 1 0 0 0 0
0 0 0 1 000 0 00 77 55 3c3 1e1d577 1 0 0 1 0 0
0 0 0 3 0c8 0 00 c8 55 3c3 1e1d577 1 0 0 1 0 0
0 0 0 1 000 1 3e 3e 55 3c3 1e1d5c8 1 0 0 0 0 0
0 0 0 4 10a 0 00 3e 0a 3c3 1e1d5c8 1 0 0 0 0 0
0 0 0 5 201 0 00 3e 0a 201 1e1d5c8 1 0 0 0 0 0
0 0 0 1 000 0 00 3e 0a 201 1008a3e 1 0 0 0 0 0
0 0 0 3 0ff 0 00 ff 0a 201 1008a3e 1 0 0 0 0 0
0 0 0 2 000 0 00 3e 0a 201 1e1d5c8 1 0 0 0 0 0
0 0 0 2 000 1 99 c8 55 3c3 1e1d577 1 0 0 1 0 0
0 0 0 2 000 0 00 77 55 3c3 0000000 0 1 0 0 0 0
0 0 0 2 000 0 00 77 55 3c3 0000000 0 1 0 0 0 1
0 0 0 1 000 1 01 01 55 3c3 1e1d577 1 0 0 1 0 1
0 0 0 1 000 1 02 02 55 3c3 1e1d501 1 0 0 0 0 1
0 0 0 1 000 1 03 03 55 3c3 1e1d502 1 0 0 0 0 1
0 0 0 1 000 1 04 04 55 3c3 1e1d503 1 0 0 0 0 1
0 0 0 1 000 1 05 05 55 3c3 1e1d504 1 0 0 0 0 1
0 0 0 1 000 1 06 06 55 3c3 1e1d505 1 0 0 0 0 1
0 0 0 1 000 1 07 07 55 3c3 1e1d506 1 0 1 0 0 1
0 0 0 1 000 0 00 07 55 3c3 1e1d506 1 0 1 0 1 1
0 0 0 6 000 0 00 07 55 3c3 1e1d506 1 0 1 0 0 0
0 0 0 2 000 0 00 06 55 3c3 1e1d505 1 0 0 0 0 0
0 1 0 3 0ff 0 00 06 55 000 1e1d506 1 0 1 0 0 0
0 0 0 5 155 0 00 06 55 155 1e1d506 1 0 1 0 0 0
0 0 1 1 000 1 aa 06 55 3c3 1e1d505 1 0 0 0 0 0
1 1 0 3 0ff 1 ff 06 55 3c3 1e1d505 1 0 0 0 0 0
1 0 1 2 000 0 00 06 55 3c3 1e1d505 1 0 0 0 0 0
1 0 0 1 000 0 00 06 55 3c3 1e1d505 1 0 0 0 0 0
0 0 0 0 000 0 00 06 55 3c3 1e1d505 1 0 0 0 0 0

// ==== vlog.f ====
hdl/dspStatusPkg.sv
hdl/stackCells.sv
hdl/statusStack.sv
hdl/statusRegs.sv
hdl/statusSeq.sv
hdl/statusTop.sv
verification/statusTb.sv

// ==== verification/statusTb.sv ====
`timescale 1ns/1ns

module statusTb;

  import dspStatusPkg::*;

  localparam int maxLines  = 200;
  localparam int maxCycles = 1000;
  localparam int rstWait   = 20;
  localparam int numCols   = 17;

  logic                  STSCLK;
  logic                  T_RST;
  logic                  hold;
  logic                  intAck;
  logic                  rti;
  stsOp                  cmd;
  logic [imaskWidth-1:0] wrData;
  logic                  aluValid;
  logic [astatWidth-1:0] aluFlags;
  logic [astatWidth-1:0] astat;
  logic [mstatWidth-1:0] mstat;
  logic [imaskWidth-1:0] imask;
  statusWord             stkTop;
  logic                  stkEmpty;
  logic                  stkFull;
  logic                  stkHas1;
  logic                  stkOverflow;
  logic                  stkUnderflow;

  int valueErrors = 0;
  int otherErrors = 0;
  int lineNo = 0;

  // columns of the data line whose effect is checked next
  int e [numCols];

  statusTop #(
    .stackDepth (7)
  ) dut_i (
    .STSCLK       (STSCLK),
    .T_RST        (T_RST),
    .hold         (hold),
    .intAck       (intAck),
    .rti          (rti),
    .cmd          (cmd),
    .wrData       (wrData),
    .aluValid     (aluValid),
    .aluFlags     (aluFlags),
    .astat        (astat),
    .mstat        (mstat),
    .imask        (imask),
    .stkTop       (stkTop),
    .stkEmpty     (stkEmpty),
    .stkFull      (stkFull),
    .stkHas1      (stkHas1),
    .stkOverflow  (stkOverflow),
    .stkUnderflow (stkUnderflow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock, reset and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    STSCLK = 1'b0;
    forever #50 STSCLK = ~STSCLK;
  end

  initial begin
    T_RST = 1'b1;
    repeat (8) @(posedge STSCLK);
    #10 T_RST = 1'b0;
  end

  initial begin
    for (int c = 0; c < maxCycles; c++) begin
      @(posedge STSCLK);
    end
    $display("simulation ran past %0d cycles without finishing", maxCycles);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input statusWord exp, input statusWord act);
    if (act !== exp) begin
      $display("FAILED %s at data line %0d: expected %h actual %h", name, lineNo, exp, act);
      valueErrors++;
    end
  endtask

  // fields are compared on their own width only
  task automatic checkField(input string name, input logic [imaskWidth-1:0] exp,
                            input logic [imaskWidth-1:0] act, input int width);
    logic [imaskWidth-1:0] mask;
    mask = (imaskWidth'(1) << width) - 1'b1;
    if ((act & mask) !== (exp & mask)) begin
      $display("FAILED %s at data line %0d: expected %h actual %h", name, lineNo,
               exp & mask, act & mask);
      valueErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s at data line %0d: expected %h actual %h", name, lineNo, exp, act);
      valueErrors++;
    end
  endtask

  task automatic checkOutputs();
    checkField("astat", imaskWidth'(e[7]), imaskWidth'(astat), astatWidth);
    checkField("mstat", imaskWidth'(e[8]), imaskWidth'(mstat), mstatWidth);
    checkField("imask", imaskWidth'(e[9]), imask, imaskWidth);
    if (e[11] != 0) begin
      checkWord("stkTop", statusWord'(e[10]), stkTop);
    end
    checkFlag("stkEmpty", e[12][0], stkEmpty);
    checkFlag("stkFull", e[13][0], stkFull);
    checkFlag("stkHas1", e[14][0], stkHas1);
    checkFlag("stkOverflow", e[15][0], stkOverflow);
    checkFlag("stkUnderflow", e[16][0], stkUnderflow);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // data-file driven stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int n;
    int waitCnt;
    int lines;
    bit havePrev;
    string text;
    int v [numCols];
    hold = 1'b0;
    intAck = 1'b0;
    rti = 1'b0;
    cmd = opNop;
    wrData = '0;
    aluValid = 1'b0;
    aluFlags = '0;
    waitCnt = 0;
    lines = 0;
    havePrev = 1'b0;
    @(posedge STSCLK);
    while (T_RST && waitCnt < rstWait) begin
      @(posedge STSCLK);
      waitCnt++;
    end
    if (T_RST) begin
      $display("reset was not released within %0d cycles", rstWait);
      otherErrors++;
    end
    fd = $fopen("verification/statusTestdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verification/statusTestdata.txt");
      otherErrors++;
    end else begin
      while (!$feof(fd) && lines < maxLines) begin
        text = "";
        n = $fgets(text, fd);
        lines++;
        if (n == 0 || text.len() < 2 || text[0] == "/") begin
          continue;
        end
        n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                    v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
        if (n != numCols) begin
          $display("malformed stimulus line %0d in the data file", lines);
          otherErrors++;
          continue;
        end
        @(posedge STSCLK);
        #10;
        hold = v[0][0];
        intAck = v[1][0];
        rti = v[2][0];
        cmd = stsOp'(v[3][2:0]);
        wrData = v[4][imaskWidth-1:0];
        aluValid = v[5][0];
        aluFlags = v[6][astatWidth-1:0];
        // outputs now show the effect of the line driven one cycle earlier
        #80;
        if (havePrev) begin
          checkOutputs();
        end
        for (int i = 0; i < numCols; i++) begin
          e[i] = v[i];
        end
        lineNo = lines;
        havePrev = 1'b1;
      end
      if (lines >= maxLines) begin
        $display("stimulus file exceeded %0d lines", maxLines);
        otherErrors++;
      end
      $fclose(fd);
      // one idle cycle to see the result of the last line
      @(posedge STSCLK);
      #10;
      hold = 1'b0;
      intAck = 1'b0;
      rti = 1'b0;
      cmd = opNop;
      aluValid = 1'b0;
      #80;
      if (havePrev) begin
        checkOutputs();
      end
    end
    $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/statusTop.sv ====
`timescale 1ns/1ns

module statusTop #(
  parameter int stackDepth = 7
) (
  input  logic                                STSCLK,
  input  logic                                T_RST,
  input  logic                                hold,
  input  logic                                intAck,
  input  logic                                rti,
  input  dspStatusPkg::stsOp                  cmd,
  input  logic [dspStatusPkg::imaskWidth-1:0] wrData,
  input  logic                                aluValid,
  input  logic [dspStatusPkg::astatWidth-1:0] aluFlags,
  output logic [dspStatusPkg::astatWidth-1:0] astat,
  output logic [dspStatusPkg::mstatWidth-1:0] mstat,
  output logic [dspStatusPkg::imaskWidth-1:0] imask,
  output dspStatusPkg::statusWord             stkTop,
  output logic                                stkEmpty,
  output logic                                stkFull,
  output logic                                stkHas1,
  output logic                                stkOverflow,
  output logic                                stkUnderflow
);

  import dspStatusPkg::*;

  logic      pushReq;
  logic      popReq;
  logic      restore;
  logic      clrImask;
  logic      wrAstat;
  logic      wrMstat;
  logic      wrImask;
  statusWord curWord;

  statusSeq seq_i (
    .STSCLK       (STSCLK),
    .T_RST        (T_RST),
    .hold         (hold),
    .intAck       (intAck),
    .rti          (rti),
    .cmd          (cmd),
    .stkFull      (stkFull),
    .stkEmpty     (stkEmpty),
    .pushReq      (pushReq),
    .popReq       (popReq),
    .restore      (restore),
    .clrImask     (clrImask),
    .wrAstat      (wrAstat),
    .wrMstat      (wrMstat),
    .wrImask      (wrImask),
    .stkOverflow  (stkOverflow),
    .stkUnderflow (stkUnderflow)
  );

  statusRegs regs_i (
    .STSCLK      (STSCLK),
    .T_RST       (T_RST),
    .hold        (hold),
    .restore     (restore),
    .clrImask    (clrImask),
    .wrAstat     (wrAstat),
    .wrMstat     (wrMstat),
    .wrImask     (wrImask),
    .aluValid    (aluValid),
    .wrData      (wrData),
    .aluFlags    (aluFlags),
    .restoreWord (stkTop),
    .astat       (astat),
    .mstat       (mstat),
    .imask       (imask),
    .statusWord  (curWord)
  );

  statusStack #(
    .stackDepth (stackDepth)
  ) stack_i (
    .STSCLK   (STSCLK),
    .T_RST    (T_RST),
    .hold     (hold),
    .pushReq  (pushReq),
    .popReq   (popReq),
    .pushData (curWord),
    .stkTop   (stkTop),
    .stkEmpty (stkEmpty),
    .stkFull  (stkFull),
    .stkHas1  (stkHas1)
  );

endmodule

// ==== hdl/statusSeq.sv ====
`timescale 1ns/1ns

module statusSeq (
  input  logic               STSCLK,
  input  logic               T_RST,
  input  logic               hold,
  input  logic               intAck,
  input  logic               rti,
  input  dspStatusPkg::stsOp cmd,
  input  logic               stkFull,
  input  logic               stkEmpty,
  output logic               pushReq,
  output logic               popReq,
  output logic               restore,
  output logic               clrImask,
  output logic               wrAstat,
  output logic               wrMstat,
  output logic               wrImask,
  output logic               stkOverflow,
  output logic               stkUnderflow
);

  import dspStatusPkg::*;

  logic pushWant;
  logic popWant;
  logic clrErr;

  //////////////////////////////////////////////////////////////////////////
  // request arbitration
  //////////////////////////////////////////////////////////////////////////

  // interrupt entry beats return, which beats the instruction opcode
  always_comb begin
    pushWant = 1'b0;
    popWant  = 1'b0;
    clrImask = 1'b0;
    wrAstat  = 1'b0;
    wrMstat  = 1'b0;
    wrImask  = 1'b0;
    clrErr   = 1'b0;
    if (!hold) begin
      if (intAck) begin
        pushWant = 1'b1;
        clrImask = 1'b1;
      end else if (rti) begin
        popWant = 1'b1;
      end else begin
        case (cmd)
          opPush:    pushWant = 1'b1;
          opPop:     popWant  = 1'b1;
          opWrAstat: wrAstat  = 1'b1;
          opWrMstat: wrMstat  = 1'b1;
          opWrImask: wrImask  = 1'b1;
          opClrErr:  clrErr   = 1'b1;
          default:   ;
        endcase
      end
    end
  end

  // only accepted requests reach the stack
  assign pushReq = pushWant && !stkFull;
  assign popReq  = popWant && !stkEmpty;
  assign restore = popReq;

  //////////////////////////////////////////////////////////////////////////
  // sticky stack errors
  //////////////////////////////////////////////////////////////////////////

  // a refusal takes precedence over a clear in the same cycle
  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      stkOverflow  <= 1'b0;
      stkUnderflow <= 1'b0;
    end else begin
      if (pushWant && stkFull) begin
        stkOverflow <= 1'b1;
      end else if (clrErr) begin
        stkOverflow <= 1'b0;
      end
      if (popWant && stkEmpty) begin
        stkUnderflow <= 1'b1;
      end else if (clrErr) begin
        stkUnderflow <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/statusRegs.sv ====
`timescale 1ns/1ns

module statusRegs (
  input  logic                                STSCLK,
  input  logic                                T_RST,
  input  logic                                hold,
  input  logic                                restore,
  input  logic                                clrImask,
  input  logic                                wrAstat,
  input  logic                                wrMstat,
  input  logic                                wrImask,
  input  logic                                aluValid,
  input  logic [dspStatusPkg::imaskWidth-1:0] wrData,
  input  logic [dspStatusPkg::astatWidth-1:0] aluFlags,
  input  dspStatusPkg::statusWord             restoreWord,
  output logic [dspStatusPkg::astatWidth-1:0] astat,
  output logic [dspStatusPkg::mstatWidth-1:0] mstat,
  output logic [dspStatusPkg::imaskWidth-1:0] imask,
  output dspStatusPkg::statusWord             statusWord
);

  import dspStatusPkg::*;

  logic [astatWidth-1:0] restAstat;
  logic [mstatWidth-1:0] restMstat;
  logic [imaskWidth-1:0] restImask;

  // unpack the word popped from the stack
  assign restAstat = restoreWord[astatLsb +: astatWidth];
  assign restMstat = restoreWord[mstatLsb +: mstatWidth];
  assign restImask = restoreWord[imaskLsb +: imaskWidth];

  //////////////////////////////////////////////////////////////////////////
  // field registers
  //////////////////////////////////////////////////////////////////////////

  // a restore wins, then a direct write, then the ALU flags
  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      astat <= '0;
    end else if (!hold) begin
      if (restore) begin
        astat <= restAstat;
      end else if (wrAstat) begin
        astat <= wrData[astatWidth-1:0];
      end else if (aluValid) begin
        astat <= aluFlags;
      end
    end
  end

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      mstat <= '0;
    end else if (!hold) begin
      if (restore) begin
        mstat <= restMstat;
      end else if (wrMstat) begin
        mstat <= wrData[mstatWidth-1:0];
      end
    end
  end

  // interrupt entry masks everything, the old mask is already on the stack
  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      imask <= '0;
    end else if (!hold) begin
      if (restore) begin
        imask <= restImask;
      end else if (clrImask) begin
        imask <= '0;
      end else if (wrImask) begin
        imask <= wrData;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // push data
  //////////////////////////////////////////////////////////////////////////

  // register outputs only, so a push saves the values from before the edge
  assign statusWord = {imask, mstat, astat};

endmodule

// ==== hdl/statusStack.sv ====
`timescale 1ns/1ns

module statusStack #(
  parameter int stackDepth = 7
) (
  input  logic                     STSCLK,
  input  logic                     T_RST,
  input  logic                     hold,
  input  logic                     pushReq,
  input  logic                     popReq,
  input  dspStatusPkg::statusWord  pushData,
  output dspStatusPkg::statusWord  stkTop,
  output logic                     stkEmpty,
  output logic                     stkFull,
  output logic                     stkHas1
);

  localparam int idxWidth = (stackDepth > 1) ? $clog2(stackDepth) : 1;

  // the level counts 0 up to stackDepth and so needs one more code
  localparam int levelWidth = $clog2(stackDepth + 1);

  localparam logic [levelWidth-1:0] fullLevel = levelWidth'(stackDepth);

  logic [levelWidth-1:0] level;
  logic [levelWidth-1:0] levelDec;
  logic                  cellWrEn;
  logic [idxWidth-1:0]   wrAddr;
  logic [idxWidth-1:0]   rdAddr;

  //////////////////////////////////////////////////////////////////////////
  // level counter
  //////////////////////////////////////////////////////////////////////////

  // requests arrive already checked against full and empty
  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      level <= '0;
    end else if (!hold) begin
      if (pushReq) begin
        level <= level + 1'b1;
      end else if (popReq) begin
        level <= levelDec;
      end
    end
  end

  assign levelDec = level - 1'b1;

  assign stkEmpty = (level == '0);
  assign stkFull  = (level == fullLevel);
  assign stkHas1  = (level == levelWidth'(1));

  //////////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////////

  // a push writes the free slot at the current level, the top sits one below
  assign cellWrEn = pushReq && !hold;
  assign wrAddr   = level[idxWidth-1:0];
  assign rdAddr   = levelDec[idxWidth-1:0];

  stackCells #(
    .stackDepth (stackDepth)
  ) cells_i (
    .STSCLK (STSCLK),
    .wrEn   (cellWrEn),
    .wrAddr (wrAddr),
    .rdAddr (rdAddr),
    .wrData (pushData),
    .rdData (stkTop)
  );

endmodule

// ==== hdl/stackCells.sv ====
`timescale 1ns/1ns

module stackCells #(
  parameter int stackDepth = 7,
  localparam int idxWidth = (stackDepth > 1) ? $clog2(stackDepth) : 1
) (
  input  logic                     STSCLK,
  input  logic                     wrEn,
  input  logic [idxWidth-1:0]      wrAddr,
  input  logic [idxWidth-1:0]      rdAddr,
  input  dspStatusPkg::statusWord  wrData,
  output dspStatusPkg::statusWord  rdData
);

  import dspStatusPkg::*;

  statusWord cells [stackDepth];

  always_ff @(posedge STSCLK) begin
    if (wrEn) begin
      cells[wrAddr] <= wrData;
    end
  end

  // combinational read so a pop sees the top entry in the same cycle
  assign rdData = cells[rdAddr];

endmodule

// ==== hdl/dspStatusPkg.sv ====
package dspStatusPkg;

  //////////////////////////////////////////////////////////////////////////
  // status field widths
  //////////////////////////////////////////////////////////////////////////

  // arithmetic flags from the ALU
  localparam int astatWidth = 8;

  // mode bits
  localparam int mstatWidth = 7;

  // interrupt mask, also the widest field and so the width of a field write
  localparam int imaskWidth = 10;

  localparam int statusWidth = astatWidth + mstatWidth + imaskWidth;

  // bit positions of the fields inside the packed status word
  localparam int astatLsb = 0;
  localparam int mstatLsb = astatLsb + astatWidth;
  localparam int imaskLsb = mstatLsb + mstatWidth;

  //////////////////////////////////////////////////////////////////////////
  // status word and opcodes
  //////////////////////////////////////////////////////////////////////////

  // layout is {IMASK, MSTAT, ASTAT} with ASTAT in the low bits
  typedef logic [statusWidth-1:0] statusWord;

  // status opcodes issued by the instruction decoder
  typedef enum logic [2:0] {
    opNop     = 3'd0,
    opPush    = 3'd1,
    opPop     = 3'd2,
    opWrAstat = 3'd3,
    opWrMstat = 3'd4,
    opWrImask = 3'd5,
    opClrErr  = 3'd6
  } stsOp;

  // code 3'd7 is reserved and acts as a nop

endpackage
